/* common/txcPkg.sv */
package txcPkg;

    // Stream and field widths
    localparam int dwordW   = 32;
    localparam int lenW     = 10;
    localparam int byteCntW = 12;
    localparam int lowAddrW = 7;
    localparam int tagW     = 8;
    localparam int idW      = 16;
    localparam int tcW      = 3;
    localparam int attrW    = 2;

    // Three-dword completion header
    localparam int hdrDwords = 3;

    // Completion kinds of which the D kinds carry a payload
    typedef enum logic [1:0] {
        CPL     = 2'd0,
        CPLD    = 2'd1,
        CPL_LK  = 2'd2,
        CPLD_LK = 2'd3
    } cplKind_e;

    // Fmt/type codes with fmt in bits 6:5
    localparam logic [6:0] fmtTypeCpl    = 7'h0A;
    localparam logic [6:0] fmtTypeCplD   = 7'h4A;
    localparam logic [6:0] fmtTypeCplLk  = 7'h0B;
    localparam logic [6:0] fmtTypeCplDLk = 7'h4B;

endpackage

/* formatter/cplFormatter.sv */
module cplFormatter (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [txcPkg::idW-1:0]             completerId,
    input  logic                               metaValid,
    output logic                               metaReady,
    input  txcPkg::cplKind_e                   metaKind,
    input  logic [txcPkg::lenW-1:0]            metaLength,
    input  logic [txcPkg::byteCntW-1:0]        metaByteCount,
    input  logic [txcPkg::lowAddrW-1:0]        metaLowAddr,
    input  logic [txcPkg::tagW-1:0]            metaTag,
    input  logic [txcPkg::idW-1:0]             metaRequesterId,
    input  logic [txcPkg::tcW-1:0]             metaTc,
    input  logic [txcPkg::attrW-1:0]           metaAttr,
    input  logic                               metaEp,
    output logic                               hdrValid,
    input  logic                               hdrReady,
    output logic [txcPkg::dwordW-1:0]          hdrDw0,
    output logic [txcPkg::dwordW-1:0]          hdrDw1,
    output logic [txcPkg::dwordW-1:0]          hdrDw2,
    output logic [txcPkg::lenW-1:0]            hdrPayloadLen
);
    import txcPkg::*;

    logic [6:0]      fmtType;
    logic            hasPayload;
    logic [lenW-1:0] lenField;

    always_comb begin
        case (metaKind)
            CPL:     fmtType = fmtTypeCpl;
            CPLD:    fmtType = fmtTypeCplD;
            CPL_LK:  fmtType = fmtTypeCplLk;
            default: fmtType = fmtTypeCplDLk;
        endcase
    end

    assign hasPayload = (metaKind == CPLD) || (metaKind == CPLD_LK);
    assign lenField   = hasPayload ? metaLength : '0;

    // One-entry register that refills in the cycle it drains
    assign metaReady = !hdrValid || hdrReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hdrValid <= 1'b0;
        end else if (metaReady) begin
            hdrValid <= metaValid;
        end
    end

    always_ff @(posedge clk) begin
        if (metaValid && metaReady) begin
            // R, fmt/type, R, TC, R, TD, EP, attr, AT, length
            hdrDw0 <= {1'b0, fmtType, 1'b0, metaTc, 4'b0, 1'b0, metaEp, metaAttr,
                       2'b0, lenField};
            // Status and BCM are always zero
            hdrDw1 <= {completerId, 3'b000, 1'b0, metaByteCount};
            hdrDw2 <= {metaRequesterId, metaTag, 1'b0, metaLowAddr};
            hdrPayloadLen <= lenField;
        end
    end

endmodule

/* assembler/payloadFifo.sv */
module payloadFifo #(
    parameter int depth = 16
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         inValid,
    output logic                         inReady,
    input  logic [txcPkg::dwordW-1:0]    inData,
    output logic                         outValid,
    input  logic                         outReady,
    output logic [txcPkg::dwordW-1:0]    outData
);
    import txcPkg::*;

    localparam int addrW = $clog2(depth);
    localparam logic [addrW:0] fullCount = (addrW + 1)'(depth);

    logic [dwordW-1:0] mem [depth];
    logic [addrW-1:0]  wrPtr;
    logic [addrW-1:0]  rdPtr;
    logic [addrW:0]    count;
    logic              push;
    logic              pop;

    assign inReady  = count != fullCount;
    assign outValid = count != '0;
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;
    assign outData  = mem[rdPtr];

    // Pointers wrap at the power-of-two depth
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= wrPtr + 1'b1;
            if (pop) rdPtr <= rdPtr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

endmodule

/* assembler/tlpAssembler.sv */
module tlpAssembler #(
    parameter int maxPayloadDwords = 64
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         hdrValid,
    output logic                         hdrReady,
    input  logic [txcPkg::dwordW-1:0]    hdrDw0,
    input  logic [txcPkg::dwordW-1:0]    hdrDw1,
    input  logic [txcPkg::dwordW-1:0]    hdrDw2,
    input  logic [txcPkg::lenW-1:0]      hdrPayloadLen,
    input  logic                         fifoValid,
    output logic                         fifoReady,
    input  logic [txcPkg::dwordW-1:0]    fifoData,
    output logic                         tlpValid,
    input  logic                         tlpReady,
    output logic [txcPkg::dwordW-1:0]    tlpData,
    output logic                         tlpStart,
    output logic                         tlpEnd
);
    import txcPkg::*;

    localparam int idxW = $clog2(hdrDwords);
    localparam int cntW = $clog2(maxPayloadDwords + 1);
    localparam logic [idxW-1:0] lastIdx = idxW'(hdrDwords - 1);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } state_e;

    state_e            state;
    logic [idxW-1:0]   idx;
    logic [cntW-1:0]   remain;
    logic [dwordW-1:0] hdrWord [hdrDwords];
    logic              beat;
    logic              hdrTake;

    assign tlpValid  = (state == HEADER) || ((state == PAYLOAD) && fifoValid);
    assign tlpStart  = (state == HEADER) && (idx == '0);
    assign tlpEnd    = ((state == HEADER) && (idx == lastIdx) && (remain == '0)) ||
                       ((state == PAYLOAD) && fifoValid && (remain == 1));
    assign tlpData   = (state == PAYLOAD) ? fifoData : hdrWord[idx];
    assign fifoReady = (state == PAYLOAD) && tlpReady;
    assign beat      = tlpValid && tlpReady;

    // Next header is taken as the last dword leaves
    assign hdrReady = (state == IDLE) || (beat && tlpEnd);
    assign hdrTake  = hdrValid && hdrReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= IDLE;
            idx    <= '0;
            remain <= '0;
        end else if (hdrTake) begin
            state  <= HEADER;
            idx    <= '0;
            remain <= hdrPayloadLen[cntW-1:0];
        end else if (beat) begin
            case (state)
                HEADER: begin
                    if (idx != lastIdx) begin
                        idx <= idx + 1'b1;
                    end else if (remain == '0) begin
                        state <= IDLE;
                    end else begin
                        state <= PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    remain <= remain - 1'b1;
                    if (remain == 1) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdrTake) begin
            hdrWord[0] <= hdrDw0;
            hdrWord[1] <= hdrDw1;
            hdrWord[2] <= hdrDw2;
        end
    end

endmodule

/* hdl/txcEngine.sv */
module txcEngine #(
    parameter int maxPayloadDwords = 64,
    parameter int fifoDepth        = 16
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [txcPkg::idW-1:0]             completerId,
    input  logic                               metaValid,
    output logic                               metaReady,
    input  txcPkg::cplKind_e                   metaKind,
    input  logic [txcPkg::lenW-1:0]            metaLength,
    input  logic [txcPkg::byteCntW-1:0]        metaByteCount,
    input  logic [txcPkg::lowAddrW-1:0]        metaLowAddr,
    input  logic [txcPkg::tagW-1:0]            metaTag,
    input  logic [txcPkg::idW-1:0]             metaRequesterId,
    input  logic [txcPkg::tcW-1:0]             metaTc,
    input  logic [txcPkg::attrW-1:0]           metaAttr,
    input  logic                               metaEp,
    input  logic                               dataValid,
    output logic                               dataReady,
    input  logic [txcPkg::dwordW-1:0]          data,
    output logic                               tlpValid,
    input  logic                               tlpReady,
    output logic [txcPkg::dwordW-1:0]          tlpData,
    output logic                               tlpStart,
    output logic                               tlpEnd
);
    import txcPkg::*;

    logic              hdrValid;
    logic              hdrReady;
    logic [dwordW-1:0] hdrDw0;
    logic [dwordW-1:0] hdrDw1;
    logic [dwordW-1:0] hdrDw2;
    logic [lenW-1:0]   hdrPayloadLen;
    logic              fifoValid;
    logic              fifoReady;
    logic [dwordW-1:0] fifoData;

    cplFormatter u_formatter (
        .clk, .rstN, .completerId,
        .metaValid, .metaReady, .metaKind, .metaLength, .metaByteCount,
        .metaLowAddr, .metaTag, .metaRequesterId, .metaTc, .metaAttr, .metaEp,
        .hdrValid, .hdrReady, .hdrDw0, .hdrDw1, .hdrDw2, .hdrPayloadLen
    );

    payloadFifo #(.depth(fifoDepth)) u_fifo (
        .clk, .rstN,
        .inValid  (dataValid),
        .inReady  (dataReady),
        .inData   (data),
        .outValid (fifoValid),
        .outReady (fifoReady),
        .outData  (fifoData)
    );

    tlpAssembler #(.maxPayloadDwords(maxPayloadDwords)) u_assembler (
        .clk, .rstN,
        .hdrValid, .hdrReady, .hdrDw0, .hdrDw1, .hdrDw2, .hdrPayloadLen,
        .fifoValid, .fifoReady, .fifoData,
        .tlpValid, .tlpReady, .tlpData, .tlpStart, .tlpEnd
    );

endmodule

/* test/txcEngine_sva.sv */
module txcEngine_sva (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         tlpValid,
    input  logic                         tlpReady,
    input  logic [txcPkg::dwordW-1:0]    tlpData,
    input  logic                         tlpStart,
    input  logic                         tlpEnd
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    // Output beat frozen while the sink stalls
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        (tlpValid && !tlpReady) |=>
            (tlpValid && $stable(tlpData) && $stable(tlpStart) && $stable(tlpEnd)))
    else begin
        failCount++;
        $error("tlp outputs changed while tlpReady was low");
    end

    flagsNeedValid: assert property (@(posedge clk) disable iff (!rstN)
        (tlpStart || tlpEnd) |-> tlpValid)
    else begin
        failCount++;
        $error("tlpStart or tlpEnd high without tlpValid");
    end

    quietInReset: assert property (@(posedge clk) !rstN |-> !tlpValid)
    else begin
        failCount++;
        $error("tlpValid high during reset");
    end

endmodule

/* test/txcChecker.sv */
module txcChecker (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         idlePhase,
    input  logic                         metaReady,
    input  logic                         dataReady,
    input  logic                         tlpValid,
    input  logic                         tlpReady,
    input  logic [txcPkg::dwordW-1:0]    tlpData,
    input  logic                         tlpStart,
    input  logic                         tlpEnd
);
    timeunit 1ns;
    timeprecision 100ps;
    import txcPkg::*;

    logic [dwordW-1:0] expData [$];
    logic              expStart [$];
    logic              expEnd [$];
    int                mismatchCount = 0;
    int                unexpectedCount = 0;
    int                beatCount = 0;

    task automatic pushExpected(input logic [dwordW-1:0] word, input logic start,
                                input logic last);
        expData.push_back(word);
        expStart.push_back(start);
        expEnd.push_back(last);
    endtask

    function automatic int pendingDwords();
        return expData.size();
    endfunction

    task automatic compareBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
            mismatchCount++;
        end
    endtask

    always @(posedge clk) begin
        // Quiet outputs and open inputs before the first metadata
        if (rstN && idlePhase) begin
            compareBit("tlpValid", 1'b0, tlpValid);
            compareBit("metaReady", 1'b1, metaReady);
            compareBit("dataReady", 1'b1, dataReady);
        end
        if (rstN && tlpValid && tlpReady) begin
            beatCount++;
            if (expData.size() == 0) begin
                $display("Output dword %h at %0t arrived with nothing left to expect",
                         tlpData, $time);
                unexpectedCount++;
            end else begin
                if (tlpData !== expData[0]) begin
                    $display("Mismatch at %0t: tlpData expected %h actual %h",
                             $time, expData[0], tlpData);
                    mismatchCount++;
                end
                compareBit("tlpStart", expStart[0], tlpStart);
                compareBit("tlpEnd", expEnd[0], tlpEnd);
                void'(expData.pop_front());
                void'(expStart.pop_front());
                void'(expEnd.pop_front());
            end
        end
    end

endmodule

/* test/txcEngineTb.sv */
module txcEngineTb;
    timeunit 1ns;
    timeprecision 100ps;
    import txcPkg::*;

    localparam int maxPayloadDwords = 64;
    localparam int fifoDepth        = 16;
    localparam int numCpl           = 200;
    localparam int metaW = lenW + byteCntW + lowAddrW + tagW + idW + tcW + attrW + 1;
    localparam int timeoutCycles = numCpl * (hdrDwords + maxPayloadDwords) * 4;

    logic                clk = 1'b0;
    logic                rstN;
    logic [idW-1:0]      completerId;
    logic                metaValid;
    logic                metaReady;
    cplKind_e            metaKind;
    logic [lenW-1:0]     metaLength;
    logic [byteCntW-1:0] metaByteCount;
    logic [lowAddrW-1:0] metaLowAddr;
    logic [tagW-1:0]     metaTag;
    logic [idW-1:0]      metaRequesterId;
    logic [tcW-1:0]      metaTc;
    logic [attrW-1:0]    metaAttr;
    logic                metaEp;
    logic                dataValid;
    logic                dataReady;
    logic [dwordW-1:0]   data;
    logic                tlpValid;
    logic                tlpReady;
    logic [dwordW-1:0]   tlpData;
    logic                tlpStart;
    logic                tlpEnd;
    logic                idlePhase;

    int                  seed = 32'h7fc3;
    int                  cycleCount = 0;
    int                  metaIdx = 0;
    int                  metaShown = -1;
    int                  dataIdx = 0;
    int                  dataShown = -1;
    int                  totalDwords = 0;
    int                  countErrors = 0;
    cplKind_e            kindArr [numCpl];
    logic [metaW-1:0]    metaArr [numCpl];
    logic [dwordW-1:0]   payloadQ [$];
    logic [lenW-1:0]     len;
    logic [byteCntW-1:0] byteCnt;
    logic [lowAddrW-1:0] lowAddr;
    logic [tagW-1:0]     tag;
    logic [idW-1:0]      reqId;
    logic [tcW-1:0]      tc;
    logic [attrW-1:0]    attr;
    logic                ep;

    txcEngine #(.maxPayloadDwords(maxPayloadDwords), .fifoDepth(fifoDepth)) u_dut (
        .clk, .rstN, .completerId,
        .metaValid, .metaReady, .metaKind, .metaLength, .metaByteCount,
        .metaLowAddr, .metaTag, .metaRequesterId, .metaTc, .metaAttr, .metaEp,
        .dataValid, .dataReady, .data,
        .tlpValid, .tlpReady, .tlpData, .tlpStart, .tlpEnd
    );

    txcChecker u_checker (
        .clk, .rstN, .idlePhase, .metaReady, .dataReady,
        .tlpValid, .tlpReady, .tlpData, .tlpStart, .tlpEnd
    );

    bind txcEngine txcEngine_sva u_sva (
        .clk(clk), .rstN(rstN), .tlpValid(tlpValid), .tlpReady(tlpReady),
        .tlpData(tlpData), .tlpStart(tlpStart), .tlpEnd(tlpEnd)
    );

    always #5 clk = ~clk;

    function automatic int unsigned randBelow(input int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;
    endfunction

    // Header dword 0 built field by field from the completion rules
    function automatic logic [31:0] expectedDw0(input cplKind_e kind, input logic [9:0] length,
                                                input logic [2:0] tcIn, input logic [1:0] attrIn,
                                                input logic epIn);
        logic [6:0] code;
        logic [9:0] lenField;
        case (kind)
            CPL:     code = 7'h0A;
            CPLD:    code = 7'h4A;
            CPL_LK:  code = 7'h0B;
            default: code = 7'h4B;
        endcase
        lenField = (kind == CPLD || kind == CPLD_LK) ? length : 10'd0;
        return (32'(code) << 24) | (32'(tcIn) << 20) | (32'(epIn) << 14) |
               (32'(attrIn) << 12) | 32'(lenField);
    endfunction

    task automatic presentMeta();
        if (!(metaValid && metaShown == metaIdx)) begin
            if (metaIdx < numCpl && randBelow(4) != 0) begin
                metaShown = metaIdx;
                metaValid = 1'b1;
                metaKind  = kindArr[metaIdx];
                {metaLength, metaByteCount, metaLowAddr, metaTag, metaRequesterId,
                 metaTc, metaAttr, metaEp} = metaArr[metaIdx];
            end else begin
                metaValid = 1'b0;
            end
        end
    endtask

    task automatic presentData();
        if (!(dataValid && dataShown == dataIdx)) begin
            if (dataIdx < payloadQ.size() && randBelow(8) != 0) begin
                dataShown = dataIdx;
                dataValid = 1'b1;
                data      = payloadQ[dataIdx];
            end else begin
                dataValid = 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rstN && metaValid && metaReady) metaIdx <= metaIdx + 1;
        if (rstN && dataValid && dataReady) dataIdx <= dataIdx + 1;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles with %0d expected dwords still missing",
                     cycleCount, u_checker.pendingDwords());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int i;
        int j;
        logic carries;
        logic [dwordW-1:0] word;
        rstN = 1'b0;
        completerId = idW'($random(seed));
        metaValid = 1'b0;
        metaKind = CPL;
        {metaLength, metaByteCount, metaLowAddr, metaTag, metaRequesterId,
         metaTc, metaAttr, metaEp} = '0;
        dataValid = 1'b0;
        data = '0;
        tlpReady = 1'b0;
        idlePhase = 1'b0;

        for (i = 0; i < numCpl; i++) begin
            kindArr[i] = cplKind_e'(2'(randBelow(4)));
            carries = (kindArr[i] == CPLD) || (kindArr[i] == CPLD_LK);
            {len, byteCnt, lowAddr, tag, reqId, tc, attr, ep} =
                metaW'({$random(seed), $random(seed)});
            if (carries) len = lenW'(1 + randBelow(maxPayloadDwords));
            metaArr[i] = {len, byteCnt, lowAddr, tag, reqId, tc, attr, ep};
            u_checker.pushExpected(expectedDw0(kindArr[i], len, tc, attr, ep), 1'b1, 1'b0);
            u_checker.pushExpected((32'(completerId) << 16) | 32'(byteCnt), 1'b0, 1'b0);
            u_checker.pushExpected((32'(reqId) << 16) | (32'(tag) << 8) | 32'(lowAddr),
                                   1'b0, !carries);
            totalDwords += hdrDwords;
            if (carries) begin
                for (j = 0; j < int'(len); j++) begin
                    word = $random(seed);
                    payloadQ.push_back(word);
                    u_checker.pushExpected(word, 1'b0, j == int'(len) - 1);
                end
                totalDwords += int'(len);
            end
        end

        repeat (10) @(negedge clk);
        rstN = 1'b1;
        tlpReady = 1'b1;
        idlePhase = 1'b1;
        repeat (8) @(negedge clk);
        idlePhase = 1'b0;

        while (u_checker.pendingDwords() != 0) begin
            presentMeta();
            presentData();
            tlpReady = (randBelow(10) >= 3);
            @(negedge clk);
        end
        metaValid = 1'b0;
        dataValid = 1'b0;
        tlpReady = 1'b1;
        // Extra cycles expose any trailing output
        repeat (20) @(negedge clk);

        if (u_checker.beatCount != totalDwords) begin
            $display("Output carried %0d dwords but the model expected %0d",
                     u_checker.beatCount, totalDwords);
            countErrors++;
        end
        $display("Errors: mismatches=%0d unexpected=%0d count=%0d assertions=%0d",
                 u_checker.mismatchCount, u_checker.unexpectedCount, countErrors,
                 u_dut.u_sva.failCount);
        if (u_checker.mismatchCount + u_checker.unexpectedCount + countErrors +
            u_dut.u_sva.failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
common/txcPkg.sv
formatter/cplFormatter.sv
assembler/payloadFifo.sv
assembler/tlpAssembler.sv
hdl/txcEngine.sv
test/txcEngine_sva.sv
test/txcChecker.sv
test/txcEngineTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= txcEngineTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
